/* Bender.yml */
package:
  name: dhcp_client

sources:
  - src/dhcp_pkg.sv
  - src/dhcp_if.sv
  - src/dhcp_rx.sv
  - src/dhcp_tx.sv
  - src/dhcp_core.sv
  - src/dhcp_top.sv
  - target: test
    files:
      - verification/dhcp_tb.sv

/* src/dhcp_core.sv */
`timescale 1ns/1ns

module dhcp_core (
  input  logic            clk,
  input  logic            fsm_rst,
  input  logic            addr_req,
  dhcp_msg_if.core        msg,
  dhcp_req_if.core        req,
  output dhcp_pkg::ipv4_t ipv4_addr,
  output logic            ipv4_addr_val,
  output logic [31:0]     lease_time,
  output logic            ipv4_addr_timeout
);

  dhcp_pkg::dhcp_state_t           state;
  logic                            addr_req_d;
  logic                            req_rise;
  logic [31:0]                     xid_cnt;
  logic [31:0]                     xid_q;
  logic [dhcp_pkg::DHCP_TIMER_W-1:0] timer;
  logic                            timer_done;
  logic                            start;
  logic                            offer_hit;
  logic                            ack_hit;

  assign req_rise   = addr_req && !addr_req_d;
  assign start      = req_rise && (state == dhcp_pkg::idle_s || state == dhcp_pkg::bound_s);
  assign timer_done = (timer == dhcp_pkg::DHCP_TIMEOUT_CYCLES - 1);
  assign offer_hit  = (state == dhcp_pkg::offer_wait_s) && msg.val && (msg.xid == xid_q) &&
                      (msg.msg_type == dhcp_pkg::DHCP_OFFER);
  assign ack_hit    = (state == dhcp_pkg::ack_wait_s) && msg.val && (msg.xid == xid_q) &&
                      (msg.msg_type == dhcp_pkg::DHCP_ACK);

  assign req.send = ((state == dhcp_pkg::discover_s) || (state == dhcp_pkg::request_s)) &&
                    !req.busy;
  assign req.xid  = xid_q;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state             <= dhcp_pkg::idle_s;
      addr_req_d        <= 1'b0;
      xid_cnt           <= 32'd0;
      timer             <= '0;
      ipv4_addr_val     <= 1'b0;
      ipv4_addr_timeout <= 1'b0;
    end else begin
      addr_req_d        <= addr_req;
      xid_cnt           <= xid_cnt + 32'd1; // free running, sampled as xid
      ipv4_addr_timeout <= 1'b0;
      case (state)
        dhcp_pkg::idle_s, dhcp_pkg::bound_s: begin
          if (start) begin
            state         <= dhcp_pkg::discover_s;
            ipv4_addr_val <= 1'b0;
          end
        end
        dhcp_pkg::discover_s, dhcp_pkg::request_s: begin
          if (!req.busy) begin // wait for the builder to go idle
            timer <= 1; // counts cycles since send
            state <= (state == dhcp_pkg::discover_s) ? dhcp_pkg::offer_wait_s
                                                     : dhcp_pkg::ack_wait_s;
          end
        end
        dhcp_pkg::offer_wait_s, dhcp_pkg::ack_wait_s: begin
          timer <= timer + 1'b1;
          if (offer_hit) state <= dhcp_pkg::request_s;
          else if (ack_hit) begin
            state         <= dhcp_pkg::bound_s;
            ipv4_addr_val <= 1'b1;
          end else if (timer_done) begin
            state             <= dhcp_pkg::idle_s;
            ipv4_addr_timeout <= 1'b1;
          end
        end
        default: state <= dhcp_pkg::idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      xid_q        <= xid_cnt;
      req.msg_type <= dhcp_pkg::DHCP_DISCOVER;
    end
    if (offer_hit) begin // offered lease goes into the REQUEST
      req.req_addr  <= msg.yiaddr;
      req.server_id <= msg.server_id;
      req.msg_type  <= dhcp_pkg::DHCP_REQUEST;
    end
    if (ack_hit) begin
      ipv4_addr  <= msg.yiaddr;
      lease_time <= msg.lease_time;
    end
  end

  a_val_timeout_excl : assert property (@(posedge clk) disable iff (fsm_rst)
    !(ipv4_addr_val && ipv4_addr_timeout));

endmodule

/* src/dhcp_if.sv */
`timescale 1ns/1ns

interface dhcp_msg_if;
  logic                val;
  dhcp_pkg::dhcp_msg_t msg_type;
  logic [31:0]         xid;
  dhcp_pkg::ipv4_t     yiaddr;
  dhcp_pkg::ipv4_t     server_id;
  logic [31:0]         lease_time;

  modport rx   (output val, msg_type, xid, yiaddr, server_id, lease_time);
  modport core (input  val, msg_type, xid, yiaddr, server_id, lease_time);
endinterface

interface dhcp_req_if;
  logic                send;
  dhcp_pkg::dhcp_msg_t msg_type;
  logic [31:0]         xid;
  dhcp_pkg::ipv4_t     req_addr;
  dhcp_pkg::ipv4_t     server_id;
  logic                busy;

  modport core (output send, msg_type, xid, req_addr, server_id, input busy);
  modport tx   (input  send, msg_type, xid, req_addr, server_id, output busy);
endinterface

/* src/dhcp_pkg.sv */
package dhcp_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_t;

  // udp source port of the server
  localparam logic [15:0] DHCP_SRV_PORT = 16'd67;

  // fixed bootp header, cookie follows right after
  localparam int DHCP_HDR_LEN   = 236;
  localparam int DHCP_OPT_START = DHCP_HDR_LEN + 4; // first option byte

  localparam logic [31:0] DHCP_COOKIE = 32'h63825363;

  localparam logic [7:0] DHCP_OPT_PAD        = 8'd0;
  localparam logic [7:0] DHCP_OPT_REQ_ADDR   = 8'd50;
  localparam logic [7:0] DHCP_OPT_LEASE_TIME = 8'd51;
  localparam logic [7:0] DHCP_OPT_MSG_TYPE   = 8'd53;
  localparam logic [7:0] DHCP_OPT_SERVER_ID  = 8'd54;
  localparam logic [7:0] DHCP_OPT_END        = 8'd255;

  // header + cookie + type option + end
  localparam logic [15:0] DHCP_DISCOVER_LEN = 16'd244;
  // adds requested address and server id options
  localparam logic [15:0] DHCP_REQUEST_LEN  = 16'd256;

  localparam int DHCP_TIMEOUT_CYCLES = 4000;
  localparam int DHCP_TIMER_W        = $clog2(DHCP_TIMEOUT_CYCLES + 1);

  typedef enum logic [7:0] {
    DHCP_DISCOVER = 8'd1,
    DHCP_OFFER    = 8'd2,
    DHCP_REQUEST  = 8'd3,
    DHCP_ACK      = 8'd5
  } dhcp_msg_t;

  typedef enum logic [2:0] {
    idle_s,
    discover_s,
    offer_wait_s,
    request_s,
    ack_wait_s,
    bound_s
  } dhcp_state_t;

  // phase of the option currently being parsed
  typedef enum logic [1:0] {
    opt_kind,
    opt_len,
    opt_data
  } opt_field_t;

endpackage

/* src/dhcp_rx.sv */
`timescale 1ns/1ns

module dhcp_rx (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic [7:0]  d,
  input  logic        v,
  input  logic        sof,
  input  logic        eof,
  input  logic [15:0] src_port,
  dhcp_msg_if.rx      msg
);

  logic                 receiving;
  logic                 active;
  logic [15:0]          byte_cnt;
  logic [15:0]          idx;
  logic [7:0]           op;
  logic [31:0]          cookie;
  logic [7:0]           type_raw;
  dhcp_pkg::opt_field_t opt_st;
  logic [7:0]           opt_code;
  logic [7:0]           opt_left;
  logic [23:0]          opt_sh;
  logic                 end_seen;
  logic                 opt_byte;
  logic                 end_now;

  assign active   = sof ? (src_port == dhcp_pkg::DHCP_SRV_PORT) : receiving;
  assign idx      = sof ? 16'd0 : byte_cnt; // position of the current byte
  assign opt_byte = active && v && !end_seen && (idx >= dhcp_pkg::DHCP_OPT_START);
  // end option may sit on the eof byte itself
  assign end_now  = end_seen || (opt_byte && opt_st == dhcp_pkg::opt_kind &&
                                 d == dhcp_pkg::DHCP_OPT_END);

  assign msg.msg_type = dhcp_pkg::dhcp_msg_t'(type_raw);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      receiving <= 1'b0;
      byte_cnt  <= 16'd0;
      opt_st    <= dhcp_pkg::opt_kind;
      end_seen  <= 1'b0;
      msg.val   <= 1'b0;
    end else begin
      msg.val <= 1'b0;
      if (sof) begin
        receiving <= (src_port == dhcp_pkg::DHCP_SRV_PORT); // port filter
        byte_cnt  <= 16'd0;
        opt_st    <= dhcp_pkg::opt_kind;
        end_seen  <= 1'b0;
      end
      if (active && v) byte_cnt <= idx + 16'd1;
      if (opt_byte) begin
        case (opt_st)
          dhcp_pkg::opt_kind: begin
            if (d == dhcp_pkg::DHCP_OPT_END) end_seen <= 1'b1;
            else if (d != dhcp_pkg::DHCP_OPT_PAD) opt_st <= dhcp_pkg::opt_len;
          end
          dhcp_pkg::opt_len:  opt_st <= (d == 8'd0) ? dhcp_pkg::opt_kind : dhcp_pkg::opt_data;
          dhcp_pkg::opt_data: if (opt_left == 8'd1) opt_st <= dhcp_pkg::opt_kind;
          default:            opt_st <= dhcp_pkg::opt_kind;
        endcase
      end
      if (active && v && eof) begin
        receiving <= 1'b0;
        msg.val   <= (op == 8'd2) && (cookie == dhcp_pkg::DHCP_COOKIE) && end_now &&
                     (idx >= dhcp_pkg::DHCP_OPT_START);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sof) type_raw <= 8'd0; // no type option means no valid type
    if (active && v) begin
      if (idx == 16'd0) op <= d;
      if (idx >= 16'd4 && idx <= 16'd7) msg.xid <= {msg.xid[23:0], d};
      if (idx >= 16'd16 && idx <= 16'd19) msg.yiaddr <= {msg.yiaddr[23:0], d};
      if (idx >= dhcp_pkg::DHCP_HDR_LEN && idx < dhcp_pkg::DHCP_OPT_START)
        cookie <= {cookie[23:0], d};
    end
    if (opt_byte) begin
      case (opt_st)
        dhcp_pkg::opt_kind: opt_code <= d;
        dhcp_pkg::opt_len:  opt_left <= d;
        dhcp_pkg::opt_data: begin
          opt_left <= opt_left - 8'd1;
          opt_sh   <= {opt_sh[15:0], d};
          if (opt_left == 8'd1) begin // last data byte of the option
            case (opt_code)
              dhcp_pkg::DHCP_OPT_MSG_TYPE:   type_raw       <= d;
              dhcp_pkg::DHCP_OPT_SERVER_ID:  msg.server_id  <= {opt_sh, d};
              dhcp_pkg::DHCP_OPT_LEASE_TIME: msg.lease_time <= {opt_sh, d};
              default: ; // unknown option, data skipped
            endcase
          end
        end
        default: ;
      endcase
    end
  end

  a_sof_eof_apart : assert property (@(posedge clk) disable iff (fsm_rst) !(sof && eof));

endmodule

/* src/dhcp_top.sv */
`timescale 1ns/1ns

module dhcp_top (
  input  logic            clk,
  input  logic            fsm_rst,
  input  logic [7:0]      rx_d,
  input  logic            rx_v,
  input  logic            rx_sof,
  input  logic            rx_eof,
  input  logic [15:0]     rx_src_port,
  output logic [7:0]      tx_d,
  output logic            tx_v,
  output logic            tx_sof,
  output logic            tx_eof,
  output logic [15:0]     tx_len,
  input  dhcp_pkg::mac_t  mac_addr,
  input  logic            addr_req,
  output dhcp_pkg::ipv4_t ipv4_addr,
  output logic            ipv4_addr_val,
  output logic [31:0]     lease_time,
  output logic            ipv4_addr_timeout
);

  dhcp_msg_if msg_if ();
  dhcp_req_if req_if ();

  dhcp_rx dhcp_rx_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .d        (rx_d),
    .v        (rx_v),
    .sof      (rx_sof),
    .eof      (rx_eof),
    .src_port (rx_src_port),
    .msg      (msg_if.rx)
  );

  dhcp_tx dhcp_tx_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .mac_addr (mac_addr),
    .req      (req_if.tx),
    .d        (tx_d),
    .v        (tx_v),
    .sof      (tx_sof),
    .eof      (tx_eof),
    .len      (tx_len)
  );

  dhcp_core dhcp_core_i (
    .clk               (clk),
    .fsm_rst           (fsm_rst),
    .addr_req          (addr_req),
    .msg               (msg_if.core),
    .req               (req_if.core),
    .ipv4_addr         (ipv4_addr),
    .ipv4_addr_val     (ipv4_addr_val),
    .lease_time        (lease_time),
    .ipv4_addr_timeout (ipv4_addr_timeout)
  );

endmodule

/* src/dhcp_tx.sv */
`timescale 1ns/1ns

module dhcp_tx (
  input  logic           clk,
  input  logic           fsm_rst,
  input  dhcp_pkg::mac_t mac_addr,
  dhcp_req_if.tx         req,
  output logic [7:0]     d,
  output logic           v,
  output logic           sof,
  output logic           eof,
  output logic [15:0]    len
);

  logic                busy;
  logic [15:0]         idx;
  logic [15:0]         opt_idx;
  logic [15:0]         len_q;
  dhcp_pkg::dhcp_msg_t type_q;
  logic                is_req;
  logic [31:0]         xid_q;
  dhcp_pkg::ipv4_t     addr_q;
  dhcp_pkg::ipv4_t     srv_q;

  // big endian byte k of a 32-bit word
  function automatic logic [7:0] word_byte(input logic [31:0] w, input logic [15:0] k);
    word_byte = w[8 * (3 - k[1:0]) +: 8];
  endfunction

  function automatic logic [7:0] mac_byte(input dhcp_pkg::mac_t m, input logic [15:0] k);
    mac_byte = m[8 * (5 - int'(k[2:0])) +: 8];
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy <= 1'b0;
      idx  <= 16'd0;
    end else if (req.send) begin
      busy <= 1'b1;
      idx  <= 16'd0;
    end else if (busy) begin
      idx <= idx + 16'd1;
      if (eof) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req.send) begin
      type_q <= req.msg_type;
      len_q  <= (req.msg_type == dhcp_pkg::DHCP_REQUEST) ? dhcp_pkg::DHCP_REQUEST_LEN
                                                          : dhcp_pkg::DHCP_DISCOVER_LEN;
      xid_q  <= req.xid;
      addr_q <= req.req_addr;
      srv_q  <= req.server_id;
    end
  end

  assign is_req   = (type_q == dhcp_pkg::DHCP_REQUEST);
  assign opt_idx  = idx - 16'(dhcp_pkg::DHCP_OPT_START);
  assign v        = busy;
  assign sof      = busy && (idx == 16'd0);
  assign eof      = busy && (idx == len_q - 16'd1);
  assign len      = len_q;
  assign req.busy = busy;

  always_comb begin
    d = 8'h00; // unused header fields stay zero
    if (idx == 16'd0 || idx == 16'd1) d = 8'd1; // op request, htype ethernet
    else if (idx == 16'd2) d = 8'd6; // hlen
    else if (idx >= 16'd4 && idx <= 16'd7) d = word_byte(xid_q, idx - 16'd4);
    else if (idx >= 16'd28 && idx <= 16'd33) d = mac_byte(mac_addr, idx - 16'd28);
    else if (idx >= dhcp_pkg::DHCP_HDR_LEN && idx < dhcp_pkg::DHCP_OPT_START)
      d = word_byte(dhcp_pkg::DHCP_COOKIE, idx - 16'(dhcp_pkg::DHCP_HDR_LEN));
    else if (opt_idx == 16'd0) d = dhcp_pkg::DHCP_OPT_MSG_TYPE;
    else if (opt_idx == 16'd1) d = 8'd1;
    else if (opt_idx == 16'd2) d = type_q;
    else if (idx == len_q - 16'd1) d = dhcp_pkg::DHCP_OPT_END;
    else if (is_req && opt_idx == 16'd3) d = dhcp_pkg::DHCP_OPT_REQ_ADDR;
    else if (is_req && (opt_idx == 16'd4 || opt_idx == 16'd10)) d = 8'd4;
    else if (is_req && opt_idx >= 16'd5 && opt_idx <= 16'd8)
      d = word_byte(addr_q, opt_idx - 16'd5);
    else if (is_req && opt_idx == 16'd9) d = dhcp_pkg::DHCP_OPT_SERVER_ID;
    else if (is_req && opt_idx >= 16'd11 && opt_idx <= 16'd14)
      d = word_byte(srv_q, opt_idx - 16'd11);
  end

  a_no_send_busy : assert property (@(posedge clk) disable iff (fsm_rst) req.send |-> !busy);

endmodule

/* verification/dhcp_tb.sv */
`timescale 1ns/1ns

module dhcp_tb;

  localparam int RX_MAX      = 320; // longest reply frame incl. extra options
  localparam int FRAME_SUM   = 4 * int'(dhcp_pkg::DHCP_DISCOVER_LEN) +
                               3 * int'(dhcp_pkg::DHCP_REQUEST_LEN) + 11 * RX_MAX;
  localparam int CYCLE_LIMIT = 5 * FRAME_SUM + dhcp_pkg::DHCP_TIMEOUT_CYCLES + 500;
  localparam int TX_WAIT     = 400;

  logic            clk;
  logic            fsm_rst;
  logic [7:0]      rx_d;
  logic            rx_v;
  logic            rx_sof;
  logic            rx_eof;
  logic [15:0]     rx_src_port;
  logic [7:0]      tx_d;
  logic            tx_v;
  logic            tx_sof;
  logic            tx_eof;
  logic [15:0]     tx_len;
  dhcp_pkg::mac_t  mac_addr;
  logic            addr_req;
  dhcp_pkg::ipv4_t ipv4_addr;
  logic            ipv4_addr_val;
  logic [31:0]     lease_time;
  logic            ipv4_addr_timeout;

  logic [31:0] lfsr;
  logic [7:0]  msg_q[$]; // frame under construction
  logic [7:0]  exp_q[$];
  logic [7:0]  cap_q[$]; // last transmitted frame
  logic [15:0] cap_len;
  logic [31:0] cur_xid;
  bit          in_frame = 1'b0;
  int          cyc = 0;
  int          sof_count = 0;
  int          frames_done = 0;
  int          stream_err = 0;
  int          to_count = 0;
  int          sof_cycle = 0;
  int          to_cycle = 0;
  int          errors = 0;
  int          err_base = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  dhcp_top dhcp_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles, the tests did not finish", cyc);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // transmit monitor, samples in mid cycle
  always @(negedge clk) begin
    if (ipv4_addr_timeout) begin
      to_count++;
      to_cycle = cyc;
    end
    if (tx_v) begin
      if (tx_sof) begin
        cap_q.delete();
        in_frame = 1'b1;
        sof_count++;
        sof_cycle = cyc;
        cap_len = tx_len;
      end else if (!in_frame) begin
        stream_err++; // byte outside a frame
      end
      cap_q.push_back(tx_d);
      if (tx_len != cap_len) stream_err++;
      if (tx_eof) begin
        in_frame = 1'b0;
        frames_done++;
      end
    end else if (in_frame) begin
      stream_err++; // gap inside a frame
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      r    = {r[30:0], lfsr[31]};
      lfsr = {lfsr[30:0], fb};
    end
    lfsr_bits = r;
  endfunction

  task automatic report_err(input string text);
    $display("ERR %0t %s", $time, text);
    errors++;
  endtask

  task automatic report_missing(input string text);
    $display("%s, seen at %0t", text, $time);
    errors++;
  endtask

  task automatic push_word(input logic [31:0] w);
    int k;
    for (k = 0; k < 4; k++) msg_q.push_back(w[8 * (3 - k) +: 8]);
  endtask

  task automatic set_word(input int pos, input logic [31:0] w);
    int k;
    for (k = 0; k < 4; k++) msg_q[pos + k] = w[8 * (3 - k) +: 8];
  endtask

  // bootp header plus cookie
  task automatic header_fill(input logic [7:0] op, input logic [31:0] xid,
                             input logic [31:0] yiaddr);
    int k;
    msg_q.delete();
    repeat (dhcp_pkg::DHCP_HDR_LEN) msg_q.push_back(8'h00);
    msg_q[0] = op;
    msg_q[1] = 8'd1;
    msg_q[2] = 8'd6;
    set_word(4, xid);
    set_word(16, yiaddr);
    for (k = 0; k < 6; k++) msg_q[28 + k] = mac_addr[8 * (5 - k) +: 8];
    push_word(dhcp_pkg::DHCP_COOKIE);
  endtask

  // pads and one unknown option, codes 60..187
  task automatic push_junk(input bit junk);
    int n;
    int k;
    if (junk) begin
      n = lfsr_bits(2);
      repeat (n) msg_q.push_back(dhcp_pkg::DHCP_OPT_PAD);
      if (lfsr_bits(1)) begin
        msg_q.push_back(8'd60 + 8'(lfsr_bits(7)));
        n = lfsr_bits(3);
        msg_q.push_back(8'(n));
        for (k = 0; k < n; k++) msg_q.push_back(8'(lfsr_bits(8)));
      end
    end
  endtask

  task automatic build_expected(input logic [7:0] mtype, input logic [31:0] addr,
                                input logic [31:0] srv);
    header_fill(8'd1, cur_xid, 32'd0);
    msg_q.push_back(dhcp_pkg::DHCP_OPT_MSG_TYPE);
    msg_q.push_back(8'd1);
    msg_q.push_back(mtype);
    if (mtype == dhcp_pkg::DHCP_REQUEST) begin
      msg_q.push_back(dhcp_pkg::DHCP_OPT_REQ_ADDR);
      msg_q.push_back(8'd4);
      push_word(addr);
      msg_q.push_back(dhcp_pkg::DHCP_OPT_SERVER_ID);
      msg_q.push_back(8'd4);
      push_word(srv);
    end
    msg_q.push_back(dhcp_pkg::DHCP_OPT_END);
    exp_q = msg_q;
  endtask

  task automatic build_reply(input logic [7:0] mtype, input logic [31:0] xid,
                             input logic [31:0] addr, input logic [31:0] srv,
                             input logic [31:0] lease, input bit junk);
    header_fill(8'd2, xid, addr);
    push_junk(junk);
    msg_q.push_back(dhcp_pkg::DHCP_OPT_MSG_TYPE);
    msg_q.push_back(8'd1);
    msg_q.push_back(mtype);
    push_junk(junk);
    msg_q.push_back(dhcp_pkg::DHCP_OPT_SERVER_ID);
    msg_q.push_back(8'd4);
    push_word(srv);
    push_junk(junk);
    msg_q.push_back(dhcp_pkg::DHCP_OPT_LEASE_TIME);
    msg_q.push_back(8'd4);
    push_word(lease);
    push_junk(junk);
    msg_q.push_back(dhcp_pkg::DHCP_OPT_END);
  endtask

  // sends the first len bytes of msg_q
  task automatic drive_frame(input logic [15:0] port, input int len, input bit gaps);
    int i;
    int n;
    for (i = 0; i < len; i++) begin
      if (gaps && i > 0) begin
        n = lfsr_bits(2);
        repeat (n) begin
          @(negedge clk);
          rx_v   = 1'b0;
          rx_sof = 1'b0;
          rx_eof = 1'b0;
        end
      end
      @(negedge clk);
      rx_d        = msg_q[i];
      rx_v        = 1'b1;
      rx_sof      = (i == 0);
      rx_eof      = (i == len - 1);
      rx_src_port = port;
    end
    @(negedge clk);
    rx_v   = 1'b0;
    rx_sof = 1'b0;
    rx_eof = 1'b0;
  endtask

  task automatic wait_tx_frame(input string what);
    int start;
    int n;
    start = frames_done;
    n = 0;
    while (frames_done == start && n < TX_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (frames_done == start) report_missing($sformatf("no %s frame within %0d cycles",
                                                       what, TX_WAIT));
  endtask

  task automatic compare_frame(input string what);
    int  i;
    bit  bad;
    bad = 1'b0;
    if (cap_len != exp_q.size())
      report_err($sformatf("%s tx_len %0d, expected %0d", what, cap_len, exp_q.size()));
    if (cap_q.size() != exp_q.size())
      report_err($sformatf("%s has %0d bytes, expected %0d", what, cap_q.size(),
                           exp_q.size()));
    for (i = 0; i < cap_q.size() && i < exp_q.size(); i++) begin
      if (!bad && cap_q[i] !== exp_q[i]) begin
        report_err($sformatf("%s byte %0d is %h, expected %h", what, i, cap_q[i],
                             exp_q[i]));
        bad = 1'b1;
      end
    end
    if (stream_err != 0) begin
      report_err($sformatf("%s stream broken %0d times", what, stream_err));
      stream_err = 0;
    end
  endtask

  task automatic start_discover();
    @(negedge clk);
    addr_req = 1'b1;
    repeat (2) @(negedge clk);
    addr_req = 1'b0;
    wait_tx_frame("DISCOVER");
    if (cap_q.size() >= 8) cur_xid = {cap_q[4], cap_q[5], cap_q[6], cap_q[7]};
    build_expected(dhcp_pkg::DHCP_DISCOVER, 32'd0, 32'd0);
    compare_frame("DISCOVER");
    if (ipv4_addr_val) report_err("ipv4_addr_val still high after addr_req");
  endtask

  task automatic run_exchange(input bit junk, input bit gaps);
    logic [31:0] addr;
    logic [31:0] srv;
    logic [31:0] lease;
    int          n;
    addr  = lfsr_bits(32);
    srv   = lfsr_bits(32);
    lease = lfsr_bits(32);
    build_reply(dhcp_pkg::DHCP_OFFER, cur_xid, addr, srv, lease, junk);
    drive_frame(dhcp_pkg::DHCP_SRV_PORT, msg_q.size(), gaps);
    wait_tx_frame("REQUEST");
    build_expected(dhcp_pkg::DHCP_REQUEST, addr, srv);
    compare_frame("REQUEST");
    lease = lfsr_bits(32); // the ACK grants its own lease time
    build_reply(dhcp_pkg::DHCP_ACK, cur_xid, addr, srv, lease, junk);
    drive_frame(dhcp_pkg::DHCP_SRV_PORT, msg_q.size(), gaps);
    n = 0;
    while (!ipv4_addr_val && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!ipv4_addr_val) begin
      report_missing("ipv4_addr_val did not rise after the ACK");
    end else begin
      if (ipv4_addr !== addr)
        report_err($sformatf("ipv4_addr %h, expected %h", ipv4_addr, addr));
      if (lease_time !== lease)
        report_err($sformatf("lease_time %h, expected %h", lease_time, lease));
    end
  endtask

  // bad frame, then nothing may be transmitted
  task automatic expect_silence(input string what, input logic [15:0] port, input int len);
    int base;
    base = sof_count;
    drive_frame(port, len, 1'b0);
    repeat (10) @(posedge clk);
    if (sof_count != base) report_err($sformatf("%s was answered", what));
  endtask

  task automatic finish_test(input int num, input string name);
    tests_run++;
    if (errors == err_base) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", num, name);
    end
    err_base = errors;
  endtask

  initial begin
    int to_base;
    int n;
    lfsr             = 32'h13257912;
    clk              = 1'b0;
    fsm_rst          = 1'b1;
    rx_d             = 8'h00;
    rx_v             = 1'b0;
    rx_sof           = 1'b0;
    rx_eof           = 1'b0;
    rx_src_port      = 16'd0;
    addr_req         = 1'b0;
    mac_addr[47:32]  = 16'(lfsr_bits(16));
    mac_addr[31:0]   = lfsr_bits(32);
    repeat (4) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    if (tx_v || tx_sof || tx_eof || ipv4_addr_val || ipv4_addr_timeout)
      report_err("outputs not idle after reset");

    start_discover();
    finish_test(1, "discover format");

    run_exchange(1'b0, 1'b1);
    finish_test(2, "full exchange");

    start_discover();
    build_reply(dhcp_pkg::DHCP_ACK, cur_xid, lfsr_bits(32), lfsr_bits(32), lfsr_bits(32), 0);
    expect_silence("early ACK", dhcp_pkg::DHCP_SRV_PORT, msg_q.size());
    build_reply(dhcp_pkg::DHCP_OFFER, cur_xid ^ 32'd1, lfsr_bits(32), lfsr_bits(32),
                lfsr_bits(32), 0);
    expect_silence("OFFER with wrong xid", dhcp_pkg::DHCP_SRV_PORT, msg_q.size());
    build_reply(dhcp_pkg::DHCP_OFFER, cur_xid, lfsr_bits(32), lfsr_bits(32), lfsr_bits(32), 0);
    expect_silence("OFFER from port 68", 16'd68, msg_q.size());
    msg_q[237] = msg_q[237] ^ 8'hff; // corrupt cookie
    expect_silence("OFFER with bad cookie", dhcp_pkg::DHCP_SRV_PORT, msg_q.size());
    msg_q[237] = msg_q[237] ^ 8'hff;
    expect_silence("truncated OFFER", dhcp_pkg::DHCP_SRV_PORT, 238);
    run_exchange(1'b0, 1'b0);
    finish_test(3, "filtering");

    start_discover();
    run_exchange(1'b1, 1'b1);
    finish_test(4, "option parsing");

    to_base = to_count;
    start_discover();
    n = 0;
    while (to_count == to_base && n < dhcp_pkg::DHCP_TIMEOUT_CYCLES + 50) begin
      @(posedge clk);
      n++;
    end
    repeat (20) @(posedge clk);
    if (to_count == to_base) begin
      report_missing("no ipv4_addr_timeout pulse after the DISCOVER");
    end else begin
      if (to_count - to_base != 1)
        report_err($sformatf("%0d timeout pulses, expected 1", to_count - to_base));
      if (to_cycle - sof_cycle != dhcp_pkg::DHCP_TIMEOUT_CYCLES - 1)
        report_err($sformatf("timeout %0d cycles after tx_sof, expected %0d",
                             to_cycle - sof_cycle, dhcp_pkg::DHCP_TIMEOUT_CYCLES - 1));
    end
    if (to_base != 0) report_err("timeout pulse during the earlier tests");
    if (ipv4_addr_val) report_err("ipv4_addr_val high after timeout");
    finish_test(5, "timeout");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/dhcp_pkg.sv
src/dhcp_if.sv
src/dhcp_rx.sv
src/dhcp_tx.sv
src/dhcp_core.sv
src/dhcp_top.sv
verification/dhcp_tb.sv
